// ==== design/afifo_defines.svh ====
`ifndef AFIFO_DEFINES_SVH
`define AFIFO_DEFINES_SVH

// word width of one FIFO entry
`define AFIFO_DATA_W 8

// entries, power of two only
`define AFIFO_DEPTH 16

// log2 of depth
`define AFIFO_ADDR_W 4

// almost-full when occupancy >= this
`define AFIFO_AFULL 12

// almost-empty when occupancy <= this
`define AFIFO_AEMPTY 2

`endif

// ==== design/afifo_pkg.sv ====
`include "afifo_defines.svh"

package afifo_pkg;

  // one data word
  typedef logic [`AFIFO_DATA_W-1:0] afifo_data_t;

  // address plus wrap bit, binary or gray
  typedef logic [`AFIFO_ADDR_W:0] afifo_ptr_t;

  // write side flags
  typedef struct packed {
    logic full;
    logic afull;
  } afifo_wr_status_t;

  // read side flags
  typedef struct packed {
    logic empty;
    logic aempty;
  } afifo_rd_status_t;

endpackage

// ==== design/afifo_dpram.sv ====
`timescale 1ns/10ps
`include "afifo_defines.svh"

module afifo_dpram import afifo_pkg::*; (
  input  logic                     wr_clk,
  input  logic                     wr_en,
  input  logic [`AFIFO_ADDR_W-1:0] wr_addr,
  input  afifo_data_t              wr_data,
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     rd_en,
  input  logic [`AFIFO_ADDR_W-1:0] rd_addr,
  output afifo_data_t              rd_data
);

  afifo_data_t mem [`AFIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== design/afifo_ptr_sync.sv ====
`timescale 1ns/10ps
`include "afifo_defines.svh"

module afifo_ptr_sync import afifo_pkg::*; (
  input  logic       dst_clk,
  input  logic       dst_rst_n,
  input  afifo_ptr_t src_gray,
  output afifo_ptr_t dst_bin
);

  afifo_ptr_t gray_meta; // first stage, may go metastable
  afifo_ptr_t gray_sync;

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= src_gray;
      gray_sync <= gray_meta;
    end
  end

  // each binary bit is the xor of all gray bits at or above it
  always_comb begin
    dst_bin[`AFIFO_ADDR_W] = gray_sync[`AFIFO_ADDR_W];
    for (int i = `AFIFO_ADDR_W - 1; i >= 0; i--) begin
      dst_bin[i] = dst_bin[i+1] ^ gray_sync[i];
    end
  end

endmodule

// ==== design/afifo_wr_ctrl.sv ====
`timescale 1ns/10ps
`include "afifo_defines.svh"

module afifo_wr_ctrl import afifo_pkg::*; (
  input  logic                     wr_clk,
  input  logic                     wr_rst_n,
  input  logic                     wr_en,
  input  afifo_ptr_t               rd_bin_wsync,
  output logic                     ram_wr_en,
  output logic [`AFIFO_ADDR_W-1:0] wr_addr,
  output afifo_ptr_t               wr_gray,
  output afifo_wr_status_t         wr_status
);

  logic       wr_accept;
  afifo_ptr_t wr_bin;
  afifo_ptr_t wr_bin_nxt;
  afifo_ptr_t wr_gray_nxt;
  afifo_ptr_t wr_used_nxt;
  logic       full_nxt;
  logic       afull_nxt;

  // writes while full are dropped
  assign wr_accept = wr_en & ~wr_status.full;

  assign wr_bin_nxt  = wr_bin + afifo_ptr_t'(wr_accept);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  // read pointer here is stale, so occupancy only overestimates
  assign wr_used_nxt = wr_bin_nxt - rd_bin_wsync;

  assign full_nxt  = (wr_used_nxt == afifo_ptr_t'(`AFIFO_DEPTH));
  assign afull_nxt = (wr_used_nxt >= afifo_ptr_t'(`AFIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt; // registered, glitch free into sync
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status.full  <= 1'b0;
      wr_status.afull <= 1'b0;
    end else begin
      wr_status.full  <= full_nxt;
      wr_status.afull <= afull_nxt;
    end
  end

  assign ram_wr_en = wr_accept;
  assign wr_addr   = wr_bin[`AFIFO_ADDR_W-1:0]; // drop wrap bit

endmodule

// ==== design/afifo_rd_ctrl.sv ====
`timescale 1ns/10ps
`include "afifo_defines.svh"

module afifo_rd_ctrl import afifo_pkg::*; (
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     rd_en,
  input  afifo_ptr_t               wr_bin_rsync,
  output logic                     ram_rd_en,
  output logic [`AFIFO_ADDR_W-1:0] rd_addr,
  output afifo_ptr_t               rd_gray,
  output logic                     rd_valid,
  output afifo_rd_status_t         rd_status
);

  logic       rd_accept;
  afifo_ptr_t rd_bin;
  afifo_ptr_t rd_bin_nxt;
  afifo_ptr_t rd_gray_nxt;
  afifo_ptr_t rd_used_nxt;
  logic       empty_nxt;
  logic       aempty_nxt;

  // reads while empty are ignored
  assign rd_accept = rd_en & ~rd_status.empty;

  assign rd_bin_nxt  = rd_bin + afifo_ptr_t'(rd_accept);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  // stale write pointer, occupancy only underestimates
  assign rd_used_nxt = wr_bin_rsync - rd_bin_nxt;

  assign empty_nxt  = (wr_bin_rsync == rd_bin_nxt);
  assign aempty_nxt = (rd_used_nxt <= afifo_ptr_t'(`AFIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
      rd_valid         <= 1'b0;
    end else begin
      rd_status.empty  <= empty_nxt;
      rd_status.aempty <= aempty_nxt;
      rd_valid         <= rd_accept; // lines up with ram output reg
    end
  end

  assign ram_rd_en = rd_accept;
  assign rd_addr   = rd_bin[`AFIFO_ADDR_W-1:0];

endmodule

// ==== design/async_fifo.sv ====
`timescale 1ns/10ps
`include "afifo_defines.svh"

module async_fifo import afifo_pkg::*; (
  input  logic             wr_clk,
  input  logic             wr_rst_n,
  input  logic             wr_en,
  input  afifo_data_t      wr_data,
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_en,
  output afifo_wr_status_t wr_status,
  output afifo_rd_status_t rd_status,
  output afifo_data_t      rd_data,
  output logic             rd_valid
);

  logic                     ram_wr_en;
  logic [`AFIFO_ADDR_W-1:0] wr_addr;
  afifo_ptr_t               wr_gray;
  afifo_ptr_t               rd_bin_wsync; // read ptr in wr_clk domain

  logic                     ram_rd_en;
  logic [`AFIFO_ADDR_W-1:0] rd_addr;
  afifo_ptr_t               rd_gray;
  afifo_ptr_t               wr_bin_rsync; // write ptr in rd_clk domain

  afifo_dpram dpram_i (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  afifo_wr_ctrl wr_ctrl_i (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_bin_wsync (rd_bin_wsync),
    .ram_wr_en    (ram_wr_en),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .wr_status    (wr_status)
  );

  afifo_rd_ctrl rd_ctrl_i (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_bin_rsync (wr_bin_rsync),
    .ram_rd_en    (ram_rd_en),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .rd_valid     (rd_valid),
    .rd_status    (rd_status)
  );

  // read to write crossing
  afifo_ptr_sync wsync_i (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .src_gray  (rd_gray),
    .dst_bin   (rd_bin_wsync)
  );

  // write to read crossing
  afifo_ptr_sync rsync_i (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .src_gray  (wr_gray),
    .dst_bin   (wr_bin_rsync)
  );

endmodule

// ==== sim/async_fifo_tb.sv ====
`timescale 1ns/10ps
`include "afifo_defines.svh"

module async_fifo_tb import afifo_pkg::*; ();

  typedef enum logic [1:0] {
    ph_quiet,
    ph_fill,
    ph_drain,
    ph_mixed
  } phase_e;

  localparam int reset_cycles = 10;
  localparam int quiet_len    = 10; // wr_clk cycles or 15 rd_clk cycles
  localparam int fill_len     = 40;
  localparam int drain_len    = 40;
  localparam int mixed_len    = 200;

  localparam int sched_len = 7 * quiet_len + 2 * fill_len + 2 * drain_len + 2 * mixed_len;
  localparam int timeout_cycles = 2 * (reset_cycles + sched_len);

  logic             wr_clk;
  logic             wr_rst_n;
  logic             wr_en;
  afifo_data_t      wr_data;
  logic             rd_clk;
  logic             rd_rst_n;
  logic             rd_en;
  afifo_wr_status_t wr_status;
  afifo_rd_status_t rd_status;
  afifo_data_t      rd_data;
  logic             rd_valid;

  afifo_data_t model_q [$]; // words written but not yet read
  logic [31:0] lfsr_state = 32'h893e_ccd6;

  phase_e phase        = ph_quiet;
  phase_e wr_drv_phase = ph_quiet; // phase behind the current wr inputs
  phase_e rd_drv_phase = ph_quiet;

  logic        exp_valid = 1'b0;
  afifo_data_t exp_word  = '0;

  int cycle_cnt   = 0;
  int wr_count    = 0;
  int rd_count    = 0;
  int drop_count  = 0;
  int empty_reads = 0;

  async_fifo dut_i (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_status (wr_status),
    .rd_status (rd_status),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

  initial begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  // rising edges of the two clocks never coincide
  initial begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // true with probability sixteenths/16
  function automatic logic chance(input int sixteenths);
    logic [31:0] r;
    r = rand_bits(4);
    return (int'(r) < sixteenths);
  endfunction

  function automatic int wr_prob(input phase_e kind);
    case (kind)
      ph_fill:  return 12;
      ph_mixed: return 12;
      default:  return 0;
    endcase
  endfunction

  // mixed rates balance out as 12/16 per 6 ns against 8/16 per 4 ns
  function automatic int rd_prob(input phase_e kind);
    case (kind)
      ph_drain: return 12;
      ph_mixed: return 8;
      default:  return 0;
    endcase
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input afifo_data_t exp);
    if (rd_data !== exp) begin
      report_failure($sformatf("error rd_data expected %h got %h", exp, rd_data));
    end
  endtask

  task automatic check_valid(input logic exp);
    if (rd_valid !== exp) begin
      report_failure($sformatf("error rd_valid expected %h got %h", exp, rd_valid));
    end
  endtask

  task automatic check_wr_status(input afifo_wr_status_t exp);
    if (wr_status !== exp) begin
      report_failure($sformatf("error wr_status expected %h got %h", exp, wr_status));
    end
  endtask

  task automatic check_rd_status(input afifo_rd_status_t exp);
    if (rd_status !== exp) begin
      report_failure($sformatf("error rd_status expected %h got %h", exp, rd_status));
    end
  endtask

  // flags match the model exactly once both sides idle long enough
  task automatic check_settled();
    afifo_wr_status_t exp_wr;
    afifo_rd_status_t exp_rd;
    int               occ;
    occ           = model_q.size();
    exp_wr.full   = (occ == `AFIFO_DEPTH);
    exp_wr.afull  = (occ >= `AFIFO_AFULL);
    exp_rd.empty  = (occ == 0);
    exp_rd.aempty = (occ <= `AFIFO_AEMPTY);
    check_wr_status(exp_wr);
    check_rd_status(exp_rd);
  endtask

  task automatic run_phase(input phase_e kind, input int len);
    @(negedge wr_clk); // away from both drive times
    phase = kind;
    repeat (len) @(posedge wr_clk);
    if (kind == ph_quiet) begin
      check_settled();
    end
  endtask

  always @(posedge wr_clk) begin : wr_side
    afifo_wr_status_t exp_st;
    if (wr_rst_n) begin
      // no reads since the last quiet period so the count is exact
      if (wr_drv_phase == ph_fill) begin
        exp_st.full  = (model_q.size() == `AFIFO_DEPTH);
        exp_st.afull = (model_q.size() >= `AFIFO_AFULL);
        check_wr_status(exp_st);
      end
      if (wr_en && !wr_status.full && model_q.size() >= `AFIFO_DEPTH) begin
        report_failure("overflow, a write was accepted into a full FIFO");
      end
      if (!wr_status.full && model_q.size() >= `AFIFO_DEPTH) begin
        report_failure("full is low while the FIFO holds a full set of words");
      end
      if (wr_en) begin
        if (wr_status.full) begin
          drop_count++;
        end else begin
          model_q.push_back(wr_data);
          wr_count++;
        end
      end
    end
    #1;
    wr_drv_phase = phase;
    wr_en        = chance(wr_prob(phase));
    if (wr_en) begin
      wr_data = afifo_data_t'(rand_bits(`AFIFO_DATA_W));
    end
  end

  always @(posedge rd_clk) begin : rd_side
    afifo_rd_status_t exp_st;
    if (rd_rst_n) begin
      check_valid(exp_valid);
      if (exp_valid) begin
        check_data(exp_word);
      end
      if (rd_drv_phase == ph_drain) begin
        exp_st.empty  = (model_q.size() == 0);
        exp_st.aempty = (model_q.size() <= `AFIFO_AEMPTY);
        check_rd_status(exp_st);
      end
      if (rd_en && !rd_status.empty && model_q.size() == 0) begin
        report_failure("underflow, a read was accepted from an empty FIFO");
      end
      if (!rd_status.empty && model_q.size() == 0) begin
        report_failure("empty is low while the FIFO holds no words");
      end
      exp_valid = 1'b0;
      if (rd_en) begin
        if (rd_status.empty) begin
          empty_reads++;
        end else begin
          exp_word  = model_q.pop_front(); // shows up with next rd_valid
          exp_valid = 1'b1;
          rd_count++;
        end
      end
    end
    #1;
    rd_drv_phase = phase;
    rd_en        = chance(rd_prob(phase));
  end

  always @(posedge wr_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      report_failure("timeout, the run took too many write clock cycles");
    end
  end

  initial begin
    afifo_wr_status_t exp_wr;
    afifo_rd_status_t exp_rd;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    fork
      begin
        repeat (reset_cycles) @(posedge wr_clk);
        #1 wr_rst_n = 1'b1;
      end
      begin
        repeat (reset_cycles) @(posedge rd_clk);
        #1 rd_rst_n = 1'b1;
      end
    join

    exp_wr.full   = 1'b0;
    exp_wr.afull  = 1'b0;
    exp_rd.empty  = 1'b1;
    exp_rd.aempty = 1'b1;
    check_wr_status(exp_wr);
    check_rd_status(exp_rd);
    check_valid(1'b0);

    run_phase(ph_quiet, quiet_len);
    run_phase(ph_fill, fill_len);
    run_phase(ph_quiet, quiet_len);
    run_phase(ph_drain, drain_len);
    run_phase(ph_quiet, quiet_len);
    run_phase(ph_mixed, mixed_len);
    run_phase(ph_quiet, quiet_len);
    run_phase(ph_fill, fill_len);
    run_phase(ph_quiet, quiet_len);
    run_phase(ph_mixed, mixed_len);
    run_phase(ph_quiet, quiet_len);
    run_phase(ph_drain, drain_len);
    run_phase(ph_quiet, quiet_len);

    $display("writes %0d, reads %0d, dropped writes %0d, reads while empty %0d",
             wr_count, rd_count, drop_count, empty_reads);
    if (model_q.size() != 0) begin
      report_failure("words were left in the FIFO after the final drain");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/afifo_pkg.sv
design/afifo_dpram.sv
design/afifo_ptr_sync.sv
design/afifo_wr_ctrl.sv
design/afifo_rd_ctrl.sv
design/async_fifo.sv
sim/async_fifo_tb.sv
